// File: mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Datapath widths
`define DATA_WIDTH 32
`define REG_ADDR_WIDTH 5
`define IMM_WIDTH 16

// Register file depth
`define REG_COUNT 32

`endif

// File: mipsIsaPkg.sv
`default_nettype none

`include "mips_macros.svh"

package mipsIsaPkg;

    typedef logic [`DATA_WIDTH-1:0] wordT;
    typedef logic [`REG_ADDR_WIDTH-1:0] regIdxT;

    typedef enum logic [5:0] {
        opRType = 6'h00,
        opBeq   = 6'h04,
        opOri   = 6'h0d,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcodeE;

    // R-type function field
    typedef enum logic [5:0] {
        functAdd = 6'h20,
        functSub = 6'h22,
        functAnd = 6'h24,
        functOr  = 6'h25,
        functSlt = 6'h2a
    } functE;

    // Immediate overlays rd, shamt and funct
    typedef struct packed {
        opcodeE     opcode;
        regIdxT     rs;
        regIdxT     rt;
        regIdxT     rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instrT;

endpackage

`default_nettype wire

// File: mipsPipePkg.sv
`default_nettype none

package mipsPipePkg;

    import mipsIsaPkg::*;

    typedef enum logic [1:0] {
        memAdd    = 2'b00,
        branchSub = 2'b01,
        rType     = 2'b10,
        orImm     = 2'b11
    } aluOpE;

    typedef enum logic [3:0] {
        aluAnd  = 4'b0000,
        aluOr   = 4'b0001,
        aluAdd  = 4'b0010,
        aluSub  = 4'b0110,
        aluSlt  = 4'b0111,
        aluNone = 4'b1111
    } aluCtrlE;

    typedef enum logic [1:0] {
        fromReg   = 2'b00,
        fromWb    = 2'b01,
        fromExMem = 2'b10
    } forwardSelE;

    typedef struct packed {
        logic  regDst;
        logic  aluSrc;
        logic  memToReg;
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        aluOpE aluOp;
    } ctrlT;

    typedef struct packed {
        ctrlT       ctrl;
        wordT       rd1;
        wordT       rd2;
        wordT       imm;
        regIdxT     rs;
        regIdxT     rt;
        regIdxT     rd;
        logic [5:0] funct;
    } idExT;

    typedef struct packed {
        logic   memRead;
        logic   memWrite;
        logic   memToReg;
        logic   regWrite;
        wordT   aluResult;
        wordT   storeData;
        regIdxT rd;
    } exMemT;

    // Register file write, also the WB forward source
    typedef struct packed {
        logic   regWrite;
        regIdxT rd;
        wordT   data;
    } wbWriteT;

endpackage

`default_nettype wire

// File: pipeIf.sv
`timescale 1ns/1ps
`default_nettype none

interface fetchDecodeIf import mipsIsaPkg::*; ();
    logic taken;
    logic hold;
    wordT branchTarget;
    wordT instr;   // IF/ID outputs
    wordT pcPlus4;

    modport decode (
        output taken, branchTarget, hold,
        input  instr, pcPlus4
    );

    modport fetch (
        input  taken, branchTarget, hold,
        output instr, pcPlus4
    );
endinterface

interface hazardIf import mipsIsaPkg::*, mipsPipePkg::*; (
    input logic clk,
    input logic reset
);
    regIdxT     idRs;
    regIdxT     idRt;
    logic       stall;
    regIdxT     exRs;
    regIdxT     exRt;
    logic       exMemRead;
    logic       exRegWrite;
    regIdxT     exMemRd;
    logic       exMemRegWrite;
    forwardSelE forwardA;
    forwardSelE forwardB;

    modport decode (output idRs, idRt, input stall);

    modport execute (
        output exRs, exRt, exMemRead, exRegWrite, exMemRd, exMemRegWrite,
        input  forwardA, forwardB
    );

    modport hazard (
        input  clk, reset, idRs, idRt, exRs, exRt, exMemRead, exRegWrite,
        input  exMemRd, exMemRegWrite,
        output stall, forwardA, forwardB
    );
endinterface

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
    import mipsIsaPkg::*;
    import mipsPipePkg::*;
(
    input  wordT    a,
    input  wordT    b,
    input  aluCtrlE ctrl,
    output wordT    result
);
    always_comb begin
        case (ctrl)
            aluAnd: result = a & b;
            aluOr:  result = a | b;
            aluAdd: result = a + b;
            aluSub: result = a - b;
            aluSlt: result = ($signed(a) < $signed(b)) ? wordT'(1) : '0;  // Signed compare
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: registerFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module registerFile
    import mipsIsaPkg::*;
    import mipsPipePkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  regIdxT  rs,
    input  regIdxT  rt,
    input  wbWriteT wb,
    output wordT    rsData,
    output wordT    rtData
);
    wordT regs [`REG_COUNT];

    // Same-cycle writeback wins over the stored value
    function automatic wordT readPort(regIdxT idx);
        if (wb.regWrite && wb.rd != '0 && wb.rd == idx)
            return wb.data;
        return regs[idx];
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end else if (wb.regWrite && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rsData = readPort(rs);
    assign rtData = readPort(rt);

    assert property (@(posedge clk) disable iff (reset) (rs == '0) |-> (rsData == '0));

endmodule

`default_nettype wire

// File: fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage
    import mipsIsaPkg::*;
(
    input  logic clk,
    input  logic reset,
    output wordT imemAddr,
    input  wordT imemData,
    fetchDecodeIf.fetch fd
);
    wordT pc;
    wordT pcPlus4;

    assign pcPlus4  = pc + 'd4;
    assign imemAddr = pc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (!fd.hold) begin
            pc <= fd.taken ? fd.branchTarget : pcPlus4;
        end
    end

    // IF/ID register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fd.instr   <= '0;
            fd.pcPlus4 <= '0;
        end else if (fd.taken) begin
            fd.instr   <= '0;  // Flush the wrong-path fetch
            fd.pcPlus4 <= '0;
        end else if (!fd.hold) begin
            fd.instr   <= imemData;
            fd.pcPlus4 <= pcPlus4;
        end
    end

    // A branch depending on a pending load would violate the beq rule
    assert property (@(posedge clk) disable iff (reset) !(fd.taken && fd.hold));

endmodule

`default_nettype wire

// File: decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module decodeStage
    import mipsIsaPkg::*;
    import mipsPipePkg::*;
(
    input  logic    clk,
    input  logic    reset,
    fetchDecodeIf.decode fd,
    hazardIf.decode hz,
    input  wbWriteT wb,
    output idExT    idEx
);
    instrT ir;
    ctrlT ctrl;
    logic isBranch;
    logic zeroExt;
    logic [`IMM_WIDTH-1:0] imm16;
    wordT imm;
    wordT rsData;
    wordT rtData;

    assign ir    = instrT'(fd.instr);
    assign imm16 = fd.instr[`IMM_WIDTH-1:0];

    registerFile regFile_i (
        .clk    (clk),
        .reset  (reset),
        .rs     (ir.rs),
        .rt     (ir.rt),
        .wb     (wb),
        .rsData (rsData),
        .rtData (rtData)
    );

    always_comb begin
        ctrl = '0;
        isBranch = 1'b0;
        zeroExt = 1'b0;
        if (fd.instr != '0) begin  // All-zero word is a nop
            case (ir.opcode)
                opRType: begin
                    ctrl.regDst = 1'b1;
                    ctrl.regWrite = 1'b1;
                    ctrl.aluOp = rType;
                end
                opLw: begin
                    ctrl.aluSrc = 1'b1;
                    ctrl.memToReg = 1'b1;
                    ctrl.regWrite = 1'b1;
                    ctrl.memRead = 1'b1;
                    ctrl.aluOp = memAdd;
                end
                opSw: begin
                    ctrl.aluSrc = 1'b1;
                    ctrl.memWrite = 1'b1;
                    ctrl.aluOp = memAdd;
                end
                opBeq: begin
                    isBranch = 1'b1;
                    ctrl.aluOp = branchSub;
                end
                opOri: begin
                    ctrl.aluSrc = 1'b1;
                    ctrl.regWrite = 1'b1;
                    ctrl.aluOp = orImm;
                    zeroExt = 1'b1;
                end
                default: ctrl = '0;
            endcase
        end
    end

    assign imm = zeroExt ? {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, imm16}
                         : {{(`DATA_WIDTH-`IMM_WIDTH){imm16[`IMM_WIDTH-1]}}, imm16};

    // Branch resolves here, no forwarding into the compare
    assign fd.taken        = isBranch && (rsData == rtData);
    assign fd.branchTarget = fd.pcPlus4 + (imm << 2);
    assign fd.hold         = hz.stall;

    assign hz.idRs = ir.rs;
    assign hz.idRt = ir.rt;

    // ID/EX register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idEx <= '0;
        end else begin
            idEx.ctrl  <= hz.stall ? ctrlT'('0) : ctrl;  // Bubble on load-use
            idEx.rd1   <= rsData;
            idEx.rd2   <= rtData;
            idEx.imm   <= imm;
            idEx.rs    <= ir.rs;
            idEx.rt    <= ir.rt;
            idEx.rd    <= ir.rd;
            idEx.funct <= ir.funct;
        end
    end

endmodule

`default_nettype wire

// File: hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit
    import mipsIsaPkg::*;
    import mipsPipePkg::*;
(
    hazardIf.hazard hz,
    input wbWriteT  wb
);
    // Youngest producer has priority
    function automatic forwardSelE pickSource(regIdxT src);
        if (hz.exMemRegWrite && hz.exMemRd != '0 && hz.exMemRd == src)
            return fromExMem;
        if (wb.regWrite && wb.rd != '0 && wb.rd == src)
            return fromWb;
        return fromReg;
    endfunction

    assign hz.forwardA = pickSource(hz.exRs);
    assign hz.forwardB = pickSource(hz.exRt);

    // Load in execute feeding the instruction in decode
    assign hz.stall = hz.exMemRead && hz.exRegWrite && hz.exRt != '0 &&
                      (hz.exRt == hz.idRs || hz.exRt == hz.idRt);

    // The bubble makes a second stall cycle impossible
    assert property (@(posedge hz.clk) disable iff (hz.reset) hz.stall |=> !hz.stall);

endmodule

`default_nettype wire

// File: executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage
    import mipsIsaPkg::*;
    import mipsPipePkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  idExT    idEx,
    hazardIf.execute hz,
    input  wbWriteT wb,
    output exMemT   exMem
);
    aluCtrlE aluCtrl;
    wordT opA;
    wordT rtFwd;
    wordT opB;
    wordT aluResult;
    regIdxT dest;

    function automatic wordT forwardValue(forwardSelE sel, wordT regVal);
        case (sel)
            fromExMem: return exMem.aluResult;
            fromWb:    return wb.data;
            default:   return regVal;
        endcase
    endfunction

    always_comb begin
        case (idEx.ctrl.aluOp)
            memAdd:    aluCtrl = aluAdd;
            branchSub: aluCtrl = aluSub;
            orImm:     aluCtrl = aluOr;
            default: begin
                case (idEx.funct)
                    functAdd: aluCtrl = aluAdd;
                    functSub: aluCtrl = aluSub;
                    functAnd: aluCtrl = aluAnd;
                    functOr:  aluCtrl = aluOr;
                    functSlt: aluCtrl = aluSlt;
                    default:  aluCtrl = aluNone;
                endcase
            end
        endcase
    end

    assign opA   = forwardValue(hz.forwardA, idEx.rd1);
    assign rtFwd = forwardValue(hz.forwardB, idEx.rd2);  // Also the store data
    assign opB   = idEx.ctrl.aluSrc ? idEx.imm : rtFwd;
    assign dest  = idEx.ctrl.regDst ? idEx.rd : idEx.rt;

    alu alu_i (
        .a      (opA),
        .b      (opB),
        .ctrl   (aluCtrl),
        .result (aluResult)
    );

    assign hz.exRs          = idEx.rs;
    assign hz.exRt          = idEx.rt;
    assign hz.exMemRead     = idEx.ctrl.memRead;
    assign hz.exRegWrite    = idEx.ctrl.regWrite;
    assign hz.exMemRd       = exMem.rd;
    assign hz.exMemRegWrite = exMem.regWrite;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exMem <= '0;
        end else begin
            exMem.memRead   <= idEx.ctrl.memRead;
            exMem.memWrite  <= idEx.ctrl.memWrite;
            exMem.memToReg  <= idEx.ctrl.memToReg;
            exMem.regWrite  <= idEx.ctrl.regWrite;
            exMem.aluResult <= aluResult;
            exMem.storeData <= rtFwd;
            exMem.rd        <= dest;
        end
    end

endmodule

`default_nettype wire

// File: memWbStage.sv
`timescale 1ns/1ps
`default_nettype none

module memWbStage
    import mipsIsaPkg::*;
    import mipsPipePkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  exMemT   exMem,
    output wordT    dmemAddr,
    output wordT    dmemWriteData,
    output logic    dmemWrite,
    output logic    dmemRead,
    input  wordT    dmemReadData,
    output wbWriteT wb
);
    logic   wbRegWrite;
    logic   wbMemToReg;
    regIdxT wbRd;
    wordT   wbAluResult;
    wordT   wbLoadData;

    assign dmemAddr      = exMem.aluResult;
    assign dmemWriteData = exMem.storeData;
    assign dmemWrite     = exMem.memWrite;
    assign dmemRead      = exMem.memRead;

    // MEM/WB register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wbRegWrite  <= 1'b0;
            wbMemToReg  <= 1'b0;
            wbRd        <= '0;
            wbAluResult <= '0;
            wbLoadData  <= '0;
        end else begin
            wbRegWrite  <= exMem.regWrite;
            wbMemToReg  <= exMem.memToReg;
            wbRd        <= exMem.rd;
            wbAluResult <= exMem.aluResult;
            wbLoadData  <= dmemReadData;
        end
    end

    assign wb.regWrite = wbRegWrite;
    assign wb.rd       = wbRd;
    assign wb.data     = wbMemToReg ? wbLoadData : wbAluResult;

    assert property (@(posedge clk) disable iff (reset) !(dmemRead && dmemWrite));
    assert property (@(posedge clk) disable iff (reset) dmemWrite |-> dmemAddr[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore
    import mipsIsaPkg::*;
    import mipsPipePkg::*;
(
    input  logic clk,
    input  logic reset,
    output wordT imemAddr,
    input  wordT imemData,
    output wordT dmemAddr,
    output wordT dmemWriteData,
    output logic dmemWrite,
    output logic dmemRead,
    input  wordT dmemReadData
);
    idExT    idEx;
    exMemT   exMem;
    wbWriteT wb;

    fetchDecodeIf fd ();
    hazardIf hz (.clk(clk), .reset(reset));

    fetchStage fetch_i (
        .clk      (clk),
        .reset    (reset),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .fd       (fd.fetch)
    );

    decodeStage decode_i (
        .clk   (clk),
        .reset (reset),
        .fd    (fd.decode),
        .hz    (hz.decode),
        .wb    (wb),
        .idEx  (idEx)
    );

    hazardUnit hazard_i (
        .hz (hz.hazard),
        .wb (wb)
    );

    executeStage execute_i (
        .clk   (clk),
        .reset (reset),
        .idEx  (idEx),
        .hz    (hz.execute),
        .wb    (wb),
        .exMem (exMem)
    );

    memWbStage memWb_i (
        .clk           (clk),
        .reset         (reset),
        .exMem         (exMem),
        .dmemAddr      (dmemAddr),
        .dmemWriteData (dmemWriteData),
        .dmemWrite     (dmemWrite),
        .dmemRead      (dmemRead),
        .dmemReadData  (dmemReadData),
        .wb            (wb)
    );

endmodule

`default_nettype wire

// File: mipsCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb import mipsIsaPkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int NUM_PROGRAMS = 20;
    localparam int PROG_LEN     = 40;
    localparam int MEM_WORDS    = 128;
    localparam int HALT_IDX     = PROG_LEN + 31;  // After the register dump
    localparam int WATCHDOG_NS  = NUM_PROGRAMS * 120 * 3 * CLK_PERIOD;

    logic clk = 1'b0;
    logic reset = 1'b1;
    wordT imemAddr;
    wordT imemData;
    wordT dmemAddr;
    wordT dmemWriteData;
    logic dmemWrite;
    logic dmemRead;
    wordT dmemReadData;

    logic [31:0] seed;
    wordT imem [MEM_WORDS];
    wordT dmem [MEM_WORDS];
    wordT modelMem [MEM_WORDS];
    wordT expAddr [$];
    wordT expData [$];

    mipsCore dut_i (
        .clk           (clk),
        .reset         (reset),
        .imemAddr      (imemAddr),
        .imemData      (imemData),
        .dmemAddr      (dmemAddr),
        .dmemWriteData (dmemWriteData),
        .dmemWrite     (dmemWrite),
        .dmemRead      (dmemRead),
        .dmemReadData  (dmemReadData)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Both memories answer in the same cycle
    assign imemData     = imem[imemAddr[8:2]];
    assign dmemReadData = dmem[dmemAddr[8:2]];

    always @(posedge clk) begin
        if (dmemWrite)
            dmem[dmemAddr[8:2]] <= dmemWriteData;
    end

    // Halves swapped so the low bits are the good ones
    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {seed[15:0], seed[31:16]};
    endfunction

    function automatic wordT rFormat(logic [5:0] funct, logic [4:0] rs, logic [4:0] rt,
                                     logic [4:0] rd);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic wordT iFormat(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                     logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic checkValue(input string what, input wordT actual, input wordT expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("Test FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic buildProgram();
        logic [31:0] rnd;
        logic [31:0] rnd2;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] wrote [PROG_LEN];
        int kind;
        int off;
        for (int i = 0; i < MEM_WORDS; i++)
            imem[i] = '0;
        for (int i = 0; i < PROG_LEN; i++) begin
            rnd  = nextRand();
            rnd2 = nextRand();
            rs   = {2'b00, rnd[2:0]};  // Only $0 to $7
            rt   = {2'b00, rnd[5:3]};
            rd   = {2'b00, rnd[8:6]};
            kind = int'(rnd[13:9]) % 9;
            wrote[i] = '0;
            case (kind)
                0: imem[i] = rFormat(functAdd, rs, rt, rd);
                1: imem[i] = rFormat(functSub, rs, rt, rd);
                2: imem[i] = rFormat(functAnd, rs, rt, rd);
                3: imem[i] = rFormat(functOr, rs, rt, rd);
                4: imem[i] = rFormat(functSlt, rs, rt, rd);
                5: imem[i] = iFormat(opOri, rs, rt, rnd2[15:0]);
                6: imem[i] = iFormat(opLw, 5'd0, rt, {8'd0, rnd2[5:0], 2'b00});
                7: imem[i] = iFormat(opSw, 5'd0, rt, {8'd0, rnd2[5:0], 2'b00});
                default: begin
                    if (rnd2[6])
                        rt = rs;  // Equal operands, so the branch is taken
                    // No recent writer along any path into the beq
                    for (int j = (i >= 5) ? i - 5 : 0; j < i; j++) begin
                        if (wrote[j] == rs)
                            rs = '0;
                        if (wrote[j] == rt)
                            rt = '0;
                    end
                    off = int'(rnd2[8:7]);
                    if (off > PROG_LEN - 1 - i)
                        off = PROG_LEN - 1 - i;
                    imem[i] = iFormat(opBeq, rs, rt, 16'(off));
                end
            endcase
            if (kind <= 4)
                wrote[i] = rd;
            else if (kind == 5 || kind == 6)
                wrote[i] = rt;
        end
        for (int r = 1; r < 32; r++)
            imem[PROG_LEN + r - 1] = iFormat(opSw, 5'd0, 5'(r), 16'((63 + r) * 4));
        imem[HALT_IDX] = iFormat(opBeq, 5'd0, 5'd0, 16'hffff);
    endtask

    // Sequential instruction-set model, no delay slot
    task automatic runModel();
        wordT regs [32];
        wordT ir;
        wordT a;
        wordT b;
        wordT res;
        wordT sext;
        wordT addr;
        int pc;
        int steps;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        pc = 0;
        steps = 0;
        while (pc != HALT_IDX && steps < 1000) begin
            ir   = imem[pc];
            a    = regs[ir[25:21]];
            b    = regs[ir[20:16]];
            sext = {{16{ir[15]}}, ir[15:0]};
            addr = a + sext;
            pc++;
            steps++;
            case (ir[31:26])
                opRType: begin
                    case (ir[5:0])
                        functAdd: res = a + b;
                        functSub: res = a - b;
                        functAnd: res = a & b;
                        functOr:  res = a | b;
                        functSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:  res = '0;
                    endcase
                    if (ir[15:11] != 0)
                        regs[ir[15:11]] = res;
                end
                opOri: begin
                    if (ir[20:16] != 0)
                        regs[ir[20:16]] = a | {16'h0000, ir[15:0]};
                end
                opLw: begin
                    if (ir[20:16] != 0)
                        regs[ir[20:16]] = modelMem[addr[8:2]];
                end
                opSw: begin
                    modelMem[addr[8:2]] = b;
                    expAddr.push_back(addr);
                    expData.push_back(b);
                end
                opBeq: begin
                    if (a == b)
                        pc = pc + $signed(sext);
                end
                default: ;
            endcase
        end
        if (pc != HALT_IDX) begin
            $display("Reference model never reached the halt instruction");
            $display("Test FAILED");
            $fatal(1, "model did not finish");
        end
    endtask

    task automatic checkStore(inout int count);
        if (expAddr.size() == 0) begin
            $display("Store to address %h at time %0t was not expected", dmemAddr, $time);
            $display("Test FAILED");
            $fatal(1, "unexpected store");
        end else begin
            checkValue("store address", dmemAddr, expAddr.pop_front());
            checkValue("store data", dmemWriteData, expData.pop_front());
            count++;
        end
    endtask

    task automatic runProgram(input int p);
        int haltCount;
        int stores;
        @(posedge clk);
        reset <= 1'b1;
        buildProgram();
        for (int i = 0; i < MEM_WORDS; i++) begin
            dmem[i] = nextRand();
            modelMem[i] = dmem[i];
        end
        runModel();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkValue("imemAddr after reset", imemAddr, 32'h0);
        checkValue("dmemWrite after reset", {31'd0, dmemWrite}, 32'h0);
        checkValue("dmemRead after reset", {31'd0, dmemRead}, 32'h0);
        haltCount = 0;
        stores = 0;
        // Halt loop alternates between the halt word and the one after it
        while (haltCount < 8) begin
            @(negedge clk);
            if (dmemWrite)
                checkStore(stores);
            if (imemAddr >= HALT_IDX * 4)
                haltCount++;
            else
                haltCount = 0;
        end
        if (expAddr.size() != 0) begin
            $display("Program %0d halted with %0d expected stores never seen", p, expAddr.size());
            $display("Test FAILED");
            $fatal(1, "missing stores");
        end else begin
            $display("Program %0d: %0d stores matched", p, stores);
        end
    endtask

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
            dmem[i] = '0;
        end
        seed = 32'd38;
        for (int p = 0; p < NUM_PROGRAMS; p++)
            runProgram(p);
        $display("Test OK");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, programs did not all finish", WATCHDOG_NS);
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
mipsIsaPkg.sv
mipsPipePkg.sv
pipeIf.sv
alu.sv
registerFile.sv
fetchStage.sv
decodeStage.sv
hazardUnit.sv
executeStage.sv
memWbStage.sv
mipsCore.sv
mipsCoreTb.sv
